// ==== design/bios_word_packer.sv ====
// Boot ROM word packer
// Joins two 16-bit download halves into one 32-bit BIOS write
// Suppressed while the homebrew BIOS is selected

module bios_word_packer
	import gba_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	download_bus_if.sink dl,
	input  logic         homebrew_bios,
	output bios_addr_t   bios_wraddr,
	output bios_word_t   bios_wrdata,
	output logic         bios_wr
);

	logic bios_we;
	assign bios_we = dl.bios_active & dl.wr & ~homebrew_bios;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_wraddr <= '0;
			bios_wrdata <= '0;
			bios_wr     <= 1'b0;
		end else begin
			bios_wr <= 1'b0;
			if (bios_we) begin
				if (!dl.addr[1]) begin
					bios_wrdata[15:0] <= dl.data;  // Lower half, wait for the pair
				end else begin
					bios_wrdata[31:16] <= dl.data;
					bios_wraddr        <= bios_addr_t'(dl.addr >> 2);
					bios_wr            <= 1'b1;
				end
			end
		end
	end

	// Writes only come out of a boot ROM transfer
	a_bios_wr_src: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |-> $past(dl.bios_active));

endmodule

// ==== design/cart_header_scan.sv ====
// Cartridge image scan
// Search for the FLASH1M_V save marker at any byte offset
// Last written address as the maximum pak word address
// Cartridge type from the index and the loaded flag

module cart_header_scan
	import gba_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	download_bus_if.sink dl,
	input  ioctl_index_t ioctl_index,
	output logic         cart_loaded,
	output cart_type_t   cart_type,
	output logic         flash_1m,
	output pak_addr_t    max_pak_addr
);

	localparam logic [71:0] MARKER = "FLASH1M_V";  // 9 bytes

	logic [63:0] hist;   // Last 8 bytes, newest in the low byte
	logic        hit_lo; // Marker ends on the even byte of this word
	logic        hit_hi; // Marker ends on the odd byte
	logic        cart_we;

	assign cart_we = dl.cart_active & dl.wr;
	assign hit_lo  = ({hist, dl.data[7:0]} == MARKER);
	assign hit_hi  = ({hist[55:0], dl.data[7:0], dl.data[15:8]} == MARKER);

	// Byte history in stream order
	always_ff @(posedge clk_sys) begin
		if (cart_we) begin
			hist <= {hist[47:0], dl.data[7:0], dl.data[15:8]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_loaded  <= 1'b0;
			cart_type    <= '0;
			flash_1m     <= 1'b0;
			max_pak_addr <= '0;
		end else begin
			if (dl.cart_start) begin
				flash_1m    <= 1'b0;              // New image, new search
				cart_type   <= ioctl_index[7:6];
				cart_loaded <= 1'b1;
			end
			if (dl.cart_end) begin
				max_pak_addr <= pak_addr_t'(dl.addr >> 2);  // Address still holds the last word
			end
			if (cart_we && (hit_lo || hit_hi)) begin
				flash_1m <= 1'b1;  // Wins over the clear
			end
		end
	end

endmodule

// ==== design/cart_quirk_table.sv ====
// Game title capture and compatibility table
// Title bytes from the cartridge header, byte swapped per word
// Match against eight known titles at the end of the title
// Quirk flags for SRAM, remap, GPIO, tilt and solar sensor
`include "gba_loader_defines.svh"

module cart_quirk_table
	import gba_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	download_bus_if.sink dl,
	output quirk_flags_t quirks
);

	localparam int ROWS    = 8;
	localparam int TITLE_W = $bits(game_title_t);

	// ============================================================
	// Compatibility table, short titles padded with zero bytes
	// ============================================================
	localparam game_title_t TITLES [ROWS] = '{
		{"ROCKY BOXING"},
		{"DBZ LGCYGOKU"},
		{"BOMBER MAN", 16'h0000},    // NES classic, needs remap
		{"SUPER MARIO", 8'h00},
		{"POKEMON EMER"},            // RTC on the GPIO port
		{"BOKTAI", 48'h000000000000},
		{"WARIOTWISTED"},            // Gyro on the GPIO port
		{"YOSHI TOPSY", 8'h00}
	};

	// Bit 0 SRAM, 1 remap, 2 GPIO, 3 tilt, 4 solar
	localparam quirk_flags_t FLAGS [ROWS] = '{
		5'b00001,
		5'b00001,
		5'b00011,
		5'b00011,
		5'b00100,
		5'b10100,  // Solar sensor behind GPIO
		5'b00100,
		5'b01000
	};

	ioctl_addr_t  title_ofs;    // Offset from the title base
	logic [6:0]   title_lsb;    // Bit slot of the current byte pair
	logic         title_wr;
	logic         title_done;   // Word just after the title
	game_title_t  title;
	quirk_flags_t match_flags;

	assign title_ofs  = dl.addr - ioctl_addr_t'(`GBA_HEADER_TITLE_BASE);
	assign title_lsb  = 7'(TITLE_W - 16) - {title_ofs[3:0], 3'b000};
	assign title_wr   = dl.cart_active & dl.wr
		& (title_ofs < ioctl_addr_t'(`GBA_TITLE_BYTES));
	assign title_done = dl.cart_active & dl.wr
		& (title_ofs == ioctl_addr_t'(`GBA_TITLE_BYTES));

	// First character lands in the top byte
	always_ff @(posedge clk_sys) begin
		if (title_wr) begin
			title[title_lsb +: 16] <= {dl.data[7:0], dl.data[15:8]};
		end
	end

	always_comb begin
		match_flags = '0;
		for (int i = 0; i < ROWS; i++) begin
			if (title == TITLES[i]) match_flags = match_flags | FLAGS[i];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			quirks <= '0;
		end else if (dl.cart_start) begin
			quirks <= '0;                    // Unknown until the title is in
		end else if (title_done) begin
			quirks <= quirks | match_flags;
		end
	end

endmodule

// ==== design/cheat_code_loader.sv ====
// Cheat code loader
// Assembles 16 bytes of the cheat file into one 128-bit code
// Low word of each field first, then the high word
// Clears the cheat list when a new cheat file begins

module cheat_code_loader
	import gba_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	download_bus_if.sink dl,
	output cheat_code_t  cheat_code,
	output logic         cheat_valid,
	output logic         cheat_clear
);

	logic code_we;
	assign code_we = dl.code_active & dl.wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_code  <= '0;
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_clear <= dl.code_start;
			cheat_valid <= 1'b0;
			if (code_we) begin
				case (dl.addr[3:0])
					4'd0:  cheat_code[111:96]  <= dl.data;  // Flags
					4'd2:  cheat_code[127:112] <= dl.data;
					4'd4:  cheat_code[79:64]   <= dl.data;  // Address
					4'd6:  cheat_code[95:80]   <= dl.data;
					4'd8:  cheat_code[47:32]   <= dl.data;  // Compare
					4'd10: cheat_code[63:48]   <= dl.data;
					4'd12: cheat_code[15:0]    <= dl.data;  // Replace
					4'd14: begin
						cheat_code[31:16] <= dl.data;
						cheat_valid       <= 1'b1;           // Code complete
					end
					default: ;
				endcase
			end
		end
	end

	// One strobe per 16-byte record
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid);

endmodule

// ==== design/download_bus_if.sv ====
// Registered download stream from the decoder to its consumers
// Word, address and strobe one cycle behind the host port
// Transfer kind levels plus start and end pulses
// source modport for the decoder, sink modport for the readers

interface download_bus_if
	import gba_loader_pkg::*;
();

	ioctl_addr_t addr;    // Byte address of the current word
	ioctl_data_t data;    // Current word
	logic        wr;      // Write strobe, one per word

	// Kind levels, never more than one high
	logic cart_active;
	logic bios_active;
	logic code_active;

	// Single cycle pulses
	logic cart_start;     // First active cycle of a cartridge
	logic cart_end;       // First idle cycle after a cartridge
	logic code_start;     // Cheat list begins

	modport source (
		output addr, data, wr,
		output cart_active, bios_active, code_active,
		output cart_start, cart_end, code_start
	);

	modport sink (
		input addr, data, wr,
		input cart_active, bios_active, code_active,
		input cart_start, cart_end, code_start
	);

endinterface

// ==== design/download_decode.sv ====
// Download port decoder
// Registers the host port onto the download bus
// Sorts each transfer into cartridge, boot ROM or cheat list
// Start and end pulses from the previous-cycle kind levels
`include "gba_loader_defines.svh"

module download_decode
	import gba_loader_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           ioctl_download,
	input  ioctl_index_t   ioctl_index,
	input  ioctl_addr_t    ioctl_addr,
	input  ioctl_data_t    ioctl_dout,
	input  logic           ioctl_wr,
	download_bus_if.source dl
);

	logic is_bios;     // Raw index decode
	logic is_code;
	logic cart_prev;   // Kind levels one cycle back
	logic code_prev;

	assign is_bios = (ioctl_index == `GBA_INDEX_BIOS);
	assign is_code = (ioctl_index == `GBA_INDEX_CHEAT);

	always_ff @(posedge clk_sys) begin
		dl.addr <= ioctl_addr;
		dl.data <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl.wr          <= 1'b0;
			dl.cart_active <= 1'b0;
			dl.bios_active <= 1'b0;
			dl.code_active <= 1'b0;
			cart_prev      <= 1'b0;
			code_prev      <= 1'b0;
		end else begin
			dl.wr          <= ioctl_wr;
			dl.bios_active <= ioctl_download & is_bios;
			dl.code_active <= ioctl_download & is_code;
			dl.cart_active <= ioctl_download & ~is_bios & ~is_code;  // Any other index
			cart_prev      <= dl.cart_active;
			code_prev      <= dl.code_active;
		end
	end

	// ============================================================
	// Transfer edges
	// ============================================================
	assign dl.cart_start = dl.cart_active & ~cart_prev;
	assign dl.cart_end   = ~dl.cart_active & cart_prev;
	assign dl.code_start = dl.code_active & ~code_prev;

	// Consumers rely on one kind at a time
	a_kind_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({dl.cart_active, dl.bios_active, dl.code_active}));

endmodule

// ==== design/gba_loader.sv ====
// Cartridge download front end, top level
// Download decoder feeding the cartridge scan, quirk table,
// BIOS word packer and cheat code loader over one download bus

module gba_loader
	import gba_loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	// Host download port
	input  logic         ioctl_download,
	input  ioctl_index_t ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  ioctl_data_t  ioctl_dout,
	input  logic         ioctl_wr,
	input  logic         homebrew_bios,   // Keep the built-in BIOS
	// Cartridge results
	output logic         cart_loaded,
	output cart_type_t   cart_type,
	output logic         flash_1m,
	output pak_addr_t    max_pak_addr,
	output quirk_flags_t quirks,
	// Boot ROM writes
	output bios_addr_t   bios_wraddr,
	output bios_word_t   bios_wrdata,
	output logic         bios_wr,
	// Cheat codes
	output cheat_code_t  cheat_code,
	output logic         cheat_valid,
	output logic         cheat_clear
);

	download_bus_if dl ();  // Registered download stream

	download_decode u_download_decode (
		.clk_sys, .reset, .ioctl_download, .ioctl_index,
		.ioctl_addr, .ioctl_dout, .ioctl_wr, .dl(dl)
	);

	cart_header_scan u_cart_header_scan (
		.clk_sys, .reset, .dl(dl), .ioctl_index,
		.cart_loaded, .cart_type, .flash_1m, .max_pak_addr
	);

	cart_quirk_table u_cart_quirk_table (.clk_sys, .reset, .dl(dl), .quirks);

	bios_word_packer u_bios_word_packer (
		.clk_sys, .reset, .dl(dl), .homebrew_bios,
		.bios_wraddr, .bios_wrdata, .bios_wr
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys, .reset, .dl(dl), .cheat_code, .cheat_valid, .cheat_clear
	);

endmodule

// ==== design/gba_loader_defines.svh ====
// Shared constants of the download front end
// Download port widths and the BIOS word address width
// Transfer index codes
// Cartridge header offsets of the game title
`ifndef GBA_LOADER_DEFINES_SVH
`define GBA_LOADER_DEFINES_SVH

// ============================================================
// Download port
// ============================================================
`define GBA_IOCTL_ADDR_W 27     // Byte address from the host
`define GBA_IOCTL_DATA_W 16     // One byte pair per write strobe

`define GBA_BIOS_ADDR_W 12      // 16 KB boot ROM as 32-bit words

// ============================================================
// Transfer kinds and header layout
// ============================================================
`define GBA_INDEX_BIOS 8'd0     // Boot ROM image
`define GBA_INDEX_CHEAT 8'd255  // Cheat list

`define GBA_HEADER_TITLE_BASE 'h0A0  // Game title in the ROM header
`define GBA_TITLE_BYTES 12           // Title length, zero padded

`endif

// ==== design/gba_loader_pkg.sv ====
// Vector types shared by the download front end
// Download port fields and transfer index
// BIOS write address and word, cheat code layout
// Cartridge scan results and the quirk flag vector
`include "gba_loader_defines.svh"

package gba_loader_pkg;

	// Host download port
	typedef logic [`GBA_IOCTL_ADDR_W-1:0] ioctl_addr_t;  // Byte address
	typedef logic [`GBA_IOCTL_DATA_W-1:0] ioctl_data_t;  // Low byte is the even address
	typedef logic [7:0] ioctl_index_t;                   // Transfer kind from the menu

	// Boot ROM writes
	typedef logic [`GBA_BIOS_ADDR_W-1:0] bios_addr_t;  // Word address
	typedef logic [31:0] bios_word_t;

	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	// Values arrive big endian, the core sorts that out
	typedef logic [127:0] cheat_code_t;

	// Cartridge scan
	typedef logic [`GBA_IOCTL_ADDR_W-3:0] pak_addr_t;      // Last byte address / 4
	typedef logic [1:0] cart_type_t;                       // Index bits 7:6
	typedef logic [`GBA_TITLE_BYTES*8-1:0] game_title_t;   // First character on top

	// Bit 0 SRAM off, 1 memory remap, 2 GPIO, 3 tilt, 4 solar
	typedef logic [4:0] quirk_flags_t;

endpackage

// ==== gba_loader.f ====
+incdir+design
design/gba_loader_pkg.sv
design/download_bus_if.sv
design/download_decode.sv
design/cart_header_scan.sv
design/cart_quirk_table.sv
design/bios_word_packer.sv
design/cheat_code_loader.sv
design/gba_loader.sv
tests/tb_gba_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_gba_loader -f gba_loader.f &&
sim_out="$(./obj_dir/Vtb_gba_loader)" &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -qx '=== PASS ===' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== tests/tb_gba_loader.sv ====
// Testbench for the download front end
// Transfer table with expected results, streamed one word per clock
// Monitor of BIOS writes, cheat codes and cheat clears
// Watchdog sized from the total stream length
`include "gba_loader_defines.svh"

module tb_gba_loader
	import gba_loader_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		ioctl_index_t index;
		game_title_t  title;       // Left aligned, zero padded
		logic         has_marker;
		int           marker_ofs;  // First byte of the save marker
		int           nbytes;      // Image length, multiple of 16
		logic         homebrew;
		quirk_flags_t exp_quirks;
	} xfer_t;

	localparam logic [71:0] SAVE_MARKER = "FLASH1M_V";

	logic clk_sys, reset, ioctl_download, ioctl_wr, homebrew_bios;
	ioctl_index_t ioctl_index;
	ioctl_addr_t  ioctl_addr;
	ioctl_data_t  ioctl_dout;
	logic cart_loaded, flash_1m, bios_wr, cheat_valid, cheat_clear;
	cart_type_t   cart_type;
	pak_addr_t    max_pak_addr;
	quirk_flags_t quirks;
	bios_addr_t   bios_wraddr;
	bios_word_t   bios_wrdata;
	cheat_code_t  cheat_code;

	logic [7:0]  img [0:511];           // Image of the current transfer
	logic [31:0] rng = 32'd80243;
	xfer_t       xfers [$];
	bios_addr_t  seen_waddr [$];         // Filled by the monitor only
	bios_word_t  seen_wdata [$];
	cheat_code_t seen_codes [$];
	int          clear_cnt = 0;
	int          errors = 0;
	int          checks = 0;
	longint      limit_ns = 0;

	gba_loader u_gba_loader (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_wr, .homebrew_bios, .cart_loaded, .cart_type, .flash_1m, .max_pak_addr,
		.quirks, .bios_wraddr, .bios_wrdata, .bios_wr, .cheat_code, .cheat_valid,
		.cheat_clear
	);

	always #4 clk_sys = ~clk_sys;  // 8 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Title text into header byte order, first character on top
	function automatic game_title_t title_bits(input string s);
		game_title_t t;
		int          i;
		t = '0;
		for (i = 0; i < s.len() && i < `GBA_TITLE_BYTES; i++) begin
			t[(`GBA_TITLE_BYTES - 1 - i) * 8 +: 8] = s.getc(i);
		end
		return t;
	endfunction

	function automatic ioctl_data_t image_word(input int a);
		return {img[a + 1], img[a]};  // Even byte in the low half
	endfunction

	function automatic logic is_cart(input ioctl_index_t idx);
		return idx != `GBA_INDEX_BIOS && idx != `GBA_INDEX_CHEAT;
	endfunction

	task automatic add_xfer(input ioctl_index_t idx, input string title, input int marker,
			input int nbytes, input logic homebrew, input quirk_flags_t exp_q);
		xfers.push_back('{idx, title_bits(title), marker >= 0, marker, nbytes, homebrew,
			exp_q});
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("Saw %0d %s pulses where %0d were expected", got, what, exp);
			errors++;
		end
	endtask

	// Random padding, then the title and the save marker on top
	task automatic build_image(input xfer_t x);
		int i;
		for (i = 0; i < x.nbytes; i++) begin
			rng    = xorshift32(rng);
			img[i] = rng[7:0];
		end
		if (is_cart(x.index)) begin
			for (i = 0; i < `GBA_TITLE_BYTES; i++) begin
				img[`GBA_HEADER_TITLE_BASE + i] = x.title[(`GBA_TITLE_BYTES - 1 - i) * 8 +: 8];
			end
		end
		if (x.has_marker) begin
			for (i = 0; i < 9; i++) img[x.marker_ofs + i] = SAVE_MARKER[(8 - i) * 8 +: 8];
		end
	endtask

	task automatic stream_image(input xfer_t x);
		int a;
		@(posedge clk_sys);
		ioctl_index    <= x.index;
		ioctl_download <= 1'b1;
		homebrew_bios  <= x.homebrew;
		for (a = 0; a < x.nbytes; a += 2) begin
			@(posedge clk_sys);
			ioctl_addr <= ioctl_addr_t'(a);
			ioctl_dout <= image_word(a);
			ioctl_wr   <= 1'b1;
		end
		@(posedge clk_sys);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;  // Address stays on the last word
	endtask

	task automatic run_xfer(input xfer_t x, input int n);
		int r;
		int b;
		int err_before;
		int bios_base;
		int code_base;
		int clear_base;
		int exp_bios;
		int exp_codes;
		err_before = errors;
		bios_base  = seen_waddr.size();
		code_base  = seen_codes.size();
		clear_base = clear_cnt;
		build_image(x);
		stream_image(x);
		repeat (3) @(posedge clk_sys);  // Results settle two edges after the stream
		@(negedge clk_sys);
		exp_bios  = (x.index == `GBA_INDEX_BIOS && !x.homebrew) ? x.nbytes / 4 : 0;
		exp_codes = (x.index == `GBA_INDEX_CHEAT) ? x.nbytes / 16 : 0;
		if (is_cart(x.index)) begin
			check_value("cart_loaded", cart_loaded, 1'b1);
			check_value("cart_type", cart_type, x.index[7:6]);
			check_value("flash_1m", flash_1m, x.has_marker);
			check_value("max_pak_addr", max_pak_addr, pak_addr_t'((x.nbytes - 2) >> 2));
			check_value("quirks", quirks, x.exp_quirks);
		end
		check_count("bios_wr", seen_waddr.size() - bios_base, exp_bios);
		for (r = 0; r < exp_bios && bios_base + r < seen_waddr.size(); r++) begin
			b = r * 4;
			check_value("bios_wraddr", seen_waddr[bios_base + r], bios_addr_t'(r));
			check_value("bios_wrdata", seen_wdata[bios_base + r],
				{image_word(b + 2), image_word(b)});
		end
		check_count("cheat_valid", seen_codes.size() - code_base, exp_codes);
		for (r = 0; r < exp_codes && code_base + r < seen_codes.size(); r++) begin
			b = r * 16;
			check_value("cheat_code", seen_codes[code_base + r],
				{image_word(b + 2), image_word(b), image_word(b + 6), image_word(b + 4),
				image_word(b + 10), image_word(b + 8), image_word(b + 14), image_word(b + 12)});
		end
		check_count("cheat_clear", clear_cnt - clear_base, exp_codes > 0 ? 1 : 0);
		$display("test %0d index %h: %s", n, x.index, errors == err_before ? "ok" : "FAILED");
	endtask

	// ============================================================
	// Output monitor, sampled away from the active edge
	// ============================================================
	always @(negedge clk_sys) begin
		if (!reset) begin
			if (bios_wr) begin
				seen_waddr.push_back(bios_wraddr);
				seen_wdata.push_back(bios_wrdata);
			end
			if (cheat_valid) seen_codes.push_back(cheat_code);
			if (cheat_clear) clear_cnt++;
		end
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Watchdog expired before all transfers finished");
		$display("=== FAIL ===");
		$finish;
	end

	// ============================================================
	// Transfer table and test sequence
	// ============================================================
	initial begin
		int n;
		int total;
		clk_sys        = 1'b0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		homebrew_bios  = 1'b0;
		add_xfer(8'h40, "ROCKY BOXING", 'h101, 320, 1'b0, 5'b00001);  // Marker at odd byte
		add_xfer(8'h81, "DBZ LGCYGOKU", -1, 192, 1'b0, 5'b00001);
		add_xfer(8'h02, "BOMBER MAN", -1, 192, 1'b0, 5'b00011);
		add_xfer(8'hC1, "SUPER MARIO", -1, 192, 1'b0, 5'b00011);
		add_xfer(8'h43, "POKEMON EMER", -1, 192, 1'b0, 5'b00100);
		add_xfer(8'h04, "BOKTAI", 'h0C0, 256, 1'b0, 5'b10100);         // Even byte
		add_xfer(8'h05, "WARIOTWISTED", -1, 192, 1'b0, 5'b00100);
		add_xfer(8'h06, "YOSHI TOPSY", -1, 192, 1'b0, 5'b01000);
		add_xfer(8'h07, "ZELDA MINISH", -1, 192, 1'b0, 5'b00000);      // Not in the table
		add_xfer(`GBA_INDEX_BIOS, "", -1, 64, 1'b0, 5'b00000);
		add_xfer(`GBA_INDEX_BIOS, "", -1, 32, 1'b1, 5'b00000);         // Homebrew kept
		add_xfer(`GBA_INDEX_CHEAT, "", -1, 64, 1'b0, 5'b00000);
		total = 10;
		for (n = 0; n < xfers.size(); n++) total += xfers[n].nbytes / 2 + 8;
		limit_ns = longint'(total) * 8 * 2;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_value("cart_loaded", cart_loaded, 0);
		check_value("cart_type", cart_type, 0);
		check_value("flash_1m", flash_1m, 0);
		check_value("max_pak_addr", max_pak_addr, 0);
		check_value("quirks", quirks, 0);
		check_value("bios_wr", bios_wr, 0);
		check_value("bios_wraddr", bios_wraddr, 0);
		check_value("bios_wrdata", bios_wrdata, 0);
		check_value("cheat_code", cheat_code, 0);
		check_value("cheat_valid", cheat_valid, 0);
		check_value("cheat_clear", cheat_clear, 0);
		$display("test 0 reset state: %s", errors == 0 ? "ok" : "FAILED");
		for (n = 0; n < xfers.size(); n++) run_xfer(xfers[n], n + 1);
		$display("%0d tests, %0d checks, %0d errors", xfers.size() + 1, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
